// File: include/asym_fifo_settings.svh
`ifndef ASYM_FIFO_SETTINGS_SVH
`define ASYM_FIFO_SETTINGS_SVH

// narrow side, one pushed entry
`define FIFO_W_DATA_W 8

// wide side, one popped word
`define FIFO_R_DATA_W 32

// banks per word, wide over narrow
`define FIFO_RATIO 4

// byte address, 64 entries deep
`define FIFO_ADDR_W 6

// word address, also the row address inside each bank
`define FIFO_R_ADDR_W 4

// byte level, one extra bit so a full FIFO fits
`define FIFO_LEVEL_W 7

// register map word address
`define WB_ADR_W 2

`endif

// File: logic/asym_fifo_pkg.sv
`include "asym_fifo_settings.svh"

package asym_fifo_pkg;

   // master to slave, classic cycle
   typedef struct packed {
      logic                      cyc;
      logic                      stb;
      logic                      we;
      logic [`WB_ADR_W-1:0]      adr;
      logic [`FIFO_R_DATA_W-1:0] dat;
   } wb_req_t;

   // slave to master
   typedef struct packed {
      logic                      ack;
      logic                      err;
      logic [`FIFO_R_DATA_W-1:0] dat;
   } wb_rsp_t;

   // words_empty means fewer than one whole word stored
   typedef struct packed {
      logic [`FIFO_LEVEL_W-1:0] level;
      logic                     words_empty;
      logic                     full;
   } fifo_status_t;

   // register map, address 3 left unmapped
   typedef enum logic [`WB_ADR_W-1:0] {
      REG_PUSH   = 2'd0,
      REG_POP    = 2'd1,
      REG_STATUS = 2'd2
   } wb_reg_e;

   typedef enum logic [1:0] {
      S_IDLE,
      S_POP_WAIT,
      S_ACK
   } wb_state_e;

endpackage

// File: logic/ram_2p_bank.sv
`timescale 1ns/1ps

module ram_2p_bank #(
   parameter int DATA_W = 8,
   parameter int ADDR_W = 4
) (
   input  logic              clk_i,
   // write port
   input  logic              w_en_i,
   input  logic [ADDR_W-1:0] w_addr_i,
   input  logic [DATA_W-1:0] w_data_i,
   // read port
   input  logic              r_en_i,
   input  logic [ADDR_W-1:0] r_addr_i,
   output logic [DATA_W-1:0] r_data_o
);

   logic [DATA_W-1:0] mem [2**ADDR_W];

   always_ff @(posedge clk_i) begin
      if (w_en_i) begin
         mem[w_addr_i] <= w_data_i;
      end
   end

   // output register holds its value between reads
   always_ff @(posedge clk_i) begin
      if (r_en_i) begin
         r_data_o <= mem[r_addr_i];
      end
   end

endmodule

// File: logic/ram_2p_asym_wler.sv
`timescale 1ns/1ps
`include "asym_fifo_settings.svh"

module ram_2p_asym_wler (
   // write port, narrow
   input  logic                                   w_en_i,
   input  logic [`FIFO_ADDR_W-1:0]                w_addr_i,
   input  logic [`FIFO_W_DATA_W-1:0]              w_data_i,
   // read port, wide
   input  logic                                   r_en_i,
   input  logic [`FIFO_R_ADDR_W-1:0]              r_addr_i,
   output logic [`FIFO_R_DATA_W-1:0]              r_data_o,
   // bank write buses
   output logic [`FIFO_RATIO-1:0]                 ext_mem_w_en_o,
   output logic [`FIFO_RATIO*`FIFO_W_DATA_W-1:0]  ext_mem_w_data_o,
   output logic [`FIFO_RATIO*`FIFO_R_ADDR_W-1:0]  ext_mem_w_addr_o,
   // bank read buses
   output logic                                   ext_mem_r_en_o,
   output logic [`FIFO_RATIO*`FIFO_R_ADDR_W-1:0]  ext_mem_r_addr_o,
   input  logic [`FIFO_RATIO*`FIFO_W_DATA_W-1:0]  ext_mem_r_data_i
);

   // low byte-address bits pick the bank
   localparam int SEL_W = `FIFO_ADDR_W - `FIFO_R_ADDR_W;
   localparam int BW    = `FIFO_W_DATA_W;
   localparam int AW    = `FIFO_R_ADDR_W;

   logic [SEL_W-1:0] w_bank;
   logic [AW-1:0]    w_row;

   assign w_bank = w_addr_i[SEL_W-1:0];
   assign w_row  = w_addr_i[`FIFO_ADDR_W-1 -: AW];

   for (genvar q = 0; q < `FIFO_RATIO; q++) begin : g_bank_bus
      // write is serial, one bank per byte
      assign ext_mem_w_en_o[q]           = w_en_i & (w_bank == SEL_W'(q));
      assign ext_mem_w_data_o[q*BW +: BW] = w_data_i;
      assign ext_mem_w_addr_o[q*AW +: AW] = w_row;

      // read is parallel, bank q fills byte lane q
      assign ext_mem_r_addr_o[q*AW +: AW] = r_addr_i;
      assign r_data_o[q*BW +: BW]         = ext_mem_r_data_i[q*BW +: BW];
   end

   assign ext_mem_r_en_o = r_en_i;

endmodule

// File: logic/asym_fifo_ctrl.sv
`timescale 1ns/1ps
`include "asym_fifo_settings.svh"

module asym_fifo_ctrl
   import asym_fifo_pkg::*;
(
   input  logic                        clk_i,
   input  logic                        rst_n_i,
   // requests from the bus slave, already checked
   input  logic                        push_i,
   input  logic [`FIFO_W_DATA_W-1:0]   push_data_i,
   input  logic                        pop_i,
   output fifo_status_t                status_o,
   // memory side
   output logic                        w_en_o,
   output logic [`FIFO_ADDR_W-1:0]     w_addr_o,
   output logic [`FIFO_W_DATA_W-1:0]   w_data_o,
   output logic                        r_en_o,
   output logic [`FIFO_R_ADDR_W-1:0]   r_addr_o
);

   localparam logic [`FIFO_LEVEL_W-1:0] WORD_BYTES = `FIFO_LEVEL_W'(`FIFO_RATIO);
   localparam logic [`FIFO_LEVEL_W-1:0] DEPTH      = `FIFO_LEVEL_W'(2**`FIFO_ADDR_W);

   logic [`FIFO_ADDR_W-1:0]   wr_ptr;
   logic [`FIFO_R_ADDR_W-1:0] rd_ptr;
   logic [`FIFO_LEVEL_W-1:0]  level;

   // byte pointer, wraps at depth
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
      end else if (push_i) begin
         wr_ptr <= wr_ptr + 1'b1;
      end
   end

   // word pointer, one step per pop
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rd_ptr <= '0;
      end else if (pop_i) begin
         rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // level counted in bytes
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         level <= '0;
      end else begin
         case ({push_i, pop_i})
            2'b10:   level <= level + 1'b1;
            2'b01:   level <= level - WORD_BYTES;
            // both at once, net three bytes out
            2'b11:   level <= level + 1'b1 - WORD_BYTES;
            default: level <= level;
         endcase
      end
   end

   always_comb begin
      status_o.level       = level;
      status_o.words_empty = (level < WORD_BYTES);
      status_o.full        = (level == DEPTH);
   end

   // write and read go out in the cycle of the request
   assign w_en_o   = push_i;
   assign w_addr_o = wr_ptr;
   assign w_data_o = push_data_i;
   assign r_en_o   = pop_i;
   assign r_addr_o = rd_ptr;

endmodule

// File: logic/asym_fifo_wb.sv
`timescale 1ns/1ps
`include "asym_fifo_settings.svh"

module asym_fifo_wb
   import asym_fifo_pkg::*;
(
   input  logic                        clk_i,
   input  logic                        rst_n_i,
   // bus side
   input  wb_req_t                     wb_req_i,
   output wb_rsp_t                     wb_rsp_o,
   // FIFO side
   input  fifo_status_t                status_i,
   input  logic [`FIFO_R_DATA_W-1:0]   pop_data_i,
   output logic                        push_o,
   output logic [`FIFO_W_DATA_W-1:0]   push_data_o,
   output logic                        pop_o
);

   wb_state_e                   state;
   wb_reg_e                     reg_sel;
   wb_rsp_t                     rsp_q;
   logic                        push_ok;
   logic                        pop_ok;
   logic                        stat_ok;
   logic [`FIFO_R_DATA_W-1:0]   status_word;

   // legality from address, direction and current status
   always_comb begin
      reg_sel = wb_reg_e'(wb_req_i.adr);
      push_ok = 1'b0;
      pop_ok  = 1'b0;
      stat_ok = 1'b0;
      case (reg_sel)
         REG_PUSH:   push_ok = wb_req_i.we && !status_i.full;
         REG_POP:    pop_ok  = !wb_req_i.we && !status_i.words_empty;
         REG_STATUS: stat_ok = !wb_req_i.we;
         default:    ;
      endcase
   end

   // level in 6:0, words_empty in 8, full in 9
   always_comb begin
      status_word                      = '0;
      status_word[`FIFO_LEVEL_W-1:0]   = status_i.level;
      status_word[8]                   = status_i.words_empty;
      status_word[9]                   = status_i.full;
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state       <= S_IDLE;
         rsp_q       <= '0;
         push_o      <= 1'b0;
         push_data_o <= '0;
         pop_o       <= 1'b0;
      end else begin
         push_o <= 1'b0;
         case (state)
            S_IDLE: begin
               if (wb_req_i.cyc && wb_req_i.stb) begin
                  if (push_ok) begin
                     push_o      <= 1'b1;
                     push_data_o <= wb_req_i.dat[`FIFO_W_DATA_W-1:0];
                     rsp_q.ack   <= 1'b1;
                     rsp_q.dat   <= '0;
                     state       <= S_ACK;
                  end else if (pop_ok) begin
                     pop_o <= 1'b1;
                     state <= S_POP_WAIT;
                  end else if (stat_ok) begin
                     rsp_q.ack <= 1'b1;
                     rsp_q.dat <= status_word;
                     state     <= S_ACK;
                  end else begin
                     rsp_q.err <= 1'b1;
                     rsp_q.dat <= '0;
                     state     <= S_ACK;
                  end
               end
            end
            S_POP_WAIT: begin
               // first cycle the banks read, second the word is ready
               if (pop_o) begin
                  pop_o <= 1'b0;
               end else begin
                  rsp_q.ack <= 1'b1;
                  rsp_q.dat <= pop_data_i;
                  state     <= S_ACK;
               end
            end
            S_ACK: begin
               // request is not looked at while acking
               rsp_q.ack <= 1'b0;
               rsp_q.err <= 1'b0;
               state     <= S_IDLE;
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   assign wb_rsp_o = rsp_q;

endmodule

// File: logic/asym_fifo_top.sv
`timescale 1ns/1ps
`include "asym_fifo_settings.svh"

module asym_fifo_top
   import asym_fifo_pkg::*;
(
   input  logic    clk_i,
   input  logic    rst_n_i,
   input  wb_req_t wb_req_i,
   output wb_rsp_t wb_rsp_o
);

   localparam int BW = `FIFO_W_DATA_W;
   localparam int AW = `FIFO_R_ADDR_W;

   fifo_status_t                     status;
   logic                             push;
   logic [BW-1:0]                    push_data;
   logic                             pop;
   logic [`FIFO_R_DATA_W-1:0]        pop_data;

   logic                             w_en;
   logic [`FIFO_ADDR_W-1:0]          w_addr;
   logic [BW-1:0]                    w_data;
   logic                             r_en;
   logic [AW-1:0]                    r_addr;

   // flat bank buses
   logic [`FIFO_RATIO-1:0]           ext_w_en;
   logic [`FIFO_RATIO*BW-1:0]        ext_w_data;
   logic [`FIFO_RATIO*AW-1:0]        ext_w_addr;
   logic                             ext_r_en;
   logic [`FIFO_RATIO*AW-1:0]        ext_r_addr;
   logic [`FIFO_RATIO*BW-1:0]        ext_r_data;

   asym_fifo_wb asym_fifo_wb_inst (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .wb_req_i    (wb_req_i),
      .wb_rsp_o    (wb_rsp_o),
      .status_i    (status),
      .pop_data_i  (pop_data),
      .push_o      (push),
      .push_data_o (push_data),
      .pop_o       (pop)
   );

   asym_fifo_ctrl asym_fifo_ctrl_inst (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .push_i      (push),
      .push_data_i (push_data),
      .pop_i       (pop),
      .status_o    (status),
      .w_en_o      (w_en),
      .w_addr_o    (w_addr),
      .w_data_o    (w_data),
      .r_en_o      (r_en),
      .r_addr_o    (r_addr)
   );

   ram_2p_asym_wler ram_2p_asym_wler_inst (
      .w_en_i           (w_en),
      .w_addr_i         (w_addr),
      .w_data_i         (w_data),
      .r_en_i           (r_en),
      .r_addr_i         (r_addr),
      .r_data_o         (pop_data),
      .ext_mem_w_en_o   (ext_w_en),
      .ext_mem_w_data_o (ext_w_data),
      .ext_mem_w_addr_o (ext_w_addr),
      .ext_mem_r_en_o   (ext_r_en),
      .ext_mem_r_addr_o (ext_r_addr),
      .ext_mem_r_data_i (ext_r_data)
   );

   // one bank per byte lane
   for (genvar q = 0; q < `FIFO_RATIO; q++) begin : g_bank
      ram_2p_bank #(
         .DATA_W (BW),
         .ADDR_W (AW)
      ) ram_2p_bank_inst (
         .clk_i    (clk_i),
         .w_en_i   (ext_w_en[q]),
         .w_addr_i (ext_w_addr[q*AW +: AW]),
         .w_data_i (ext_w_data[q*BW +: BW]),
         .r_en_i   (ext_r_en),
         .r_addr_i (ext_r_addr[q*AW +: AW]),
         .r_data_o (ext_r_data[q*BW +: BW])
      );
   end

endmodule

// File: tests/asym_fifo_tb.sv
`timescale 1ns/1ps
`include "asym_fifo_settings.svh"

module asym_fifo_tb
   import asym_fifo_pkg::*;
();

   localparam time CLK_PERIOD   = 20;
   localparam time DRIVE_DLY    = 2;
   localparam int  RESET_CYCLES = 16;
   localparam int  ACK_TIMEOUT  = 50;

   logic    clk;
   logic    rst_n;
   wb_req_t wb_req;
   wb_rsp_t wb_rsp;

   integer  seed;
   int      line_no;
   int      mismatch_cnt;
   int      timeout_cnt;
   int      other_cnt;
   int      transfer_cnt;

   asym_fifo_top asym_fifo_top_inst (
      .clk_i    (clk),
      .rst_n_i  (rst_n),
      .wb_req_i (wb_req),
      .wb_rsp_o (wb_rsp)
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD/2) clk = ~clk;

   // ack and err must match, data only where the mask is set
   task automatic check_rsp(input wb_rsp_t exp, input wb_rsp_t got,
                            input logic [`FIFO_R_DATA_W-1:0] mask);
      if (got.ack !== exp.ack) begin
         $display("MISMATCH time=%0t line %0d wb_rsp_o.ack expected %b actual %b",
                  $time, line_no, exp.ack, got.ack);
         mismatch_cnt++;
      end
      if (got.err !== exp.err) begin
         $display("MISMATCH time=%0t line %0d wb_rsp_o.err expected %b actual %b",
                  $time, line_no, exp.err, got.err);
         mismatch_cnt++;
      end
      if ((got.dat & mask) !== (exp.dat & mask)) begin
         $display("MISMATCH time=%0t line %0d wb_rsp_o.dat expected %h actual %h",
                  $time, line_no, exp.dat & mask, got.dat & mask);
         mismatch_cnt++;
      end
   endtask

   task automatic check_status(input fifo_status_t exp, input fifo_status_t got);
      if (got.level !== exp.level) begin
         $display("MISMATCH time=%0t line %0d status.level expected %0d actual %0d",
                  $time, line_no, exp.level, got.level);
         mismatch_cnt++;
      end
      if (got.words_empty !== exp.words_empty) begin
         $display("MISMATCH time=%0t line %0d status.words_empty expected %b actual %b",
                  $time, line_no, exp.words_empty, got.words_empty);
         mismatch_cnt++;
      end
      if (got.full !== exp.full) begin
         $display("MISMATCH time=%0t line %0d status.full expected %b actual %b",
                  $time, line_no, exp.full, got.full);
         mismatch_cnt++;
      end
   endtask

   // bus layout of the status register
   function automatic fifo_status_t word_to_status(input logic [`FIFO_R_DATA_W-1:0] word);
      word_to_status.level       = word[`FIFO_LEVEL_W-1:0];
      word_to_status.words_empty = word[8];
      word_to_status.full        = word[9];
   endfunction

   function automatic bit decode_op(input logic [8*16-1:0] op, output logic we,
                                    output logic [`WB_ADR_W-1:0] adr);
      decode_op = 1'b1;
      we        = 1'b0;
      adr       = REG_PUSH;
      case (op)
         "push":      we = 1'b1;
         "pop":       adr = REG_POP;
         "status":    adr = REG_STATUS;
         "rd_push":   adr = REG_PUSH;
         "wr_pop": begin
            we  = 1'b1;
            adr = REG_POP;
         end
         "wr_status": begin
            we  = 1'b1;
            adr = REG_STATUS;
         end
         "rd_adr3":   adr = 2'd3;
         "wr_adr3": begin
            we  = 1'b1;
            adr = 2'd3;
         end
         default:     decode_op = 1'b0;
      endcase
   endfunction

   // entered and left just after a rising edge
   task automatic run_transfer(input logic we, input logic [`WB_ADR_W-1:0] adr,
                               input logic [`FIFO_R_DATA_W-1:0] dat,
                               output wb_rsp_t rsp, output bit timed_out);
      int n;
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we  = we;
      wb_req.adr = adr;
      wb_req.dat = dat;
      rsp        = '0;
      timed_out  = 1'b1;
      n          = 0;
      while (timed_out && n < ACK_TIMEOUT) begin
         @(posedge clk);
         #(DRIVE_DLY);
         if (wb_rsp.ack || wb_rsp.err) begin
            rsp       = wb_rsp;
            timed_out = 1'b0;
         end
         n++;
      end
      wb_req = '0;
      transfer_cnt++;
      if (timed_out) begin
         $display("ERROR: line %0d, the DUT gave neither ack nor err within %0d cycles",
                  line_no, ACK_TIMEOUT);
      end
   endtask

   initial begin
      int                          fd;
      int                          nf;
      int                          count;
      int                          err_flag;
      int                          gap;
      int                          i;
      reg [8*128-1:0]              line_buf;
      reg [8*16-1:0]               op;
      logic [`FIFO_R_DATA_W-1:0]   data;
      logic [`FIFO_R_DATA_W-1:0]   exp_word;
      logic [`FIFO_R_DATA_W-1:0]   mask;
      logic                        we;
      logic [`WB_ADR_W-1:0]        adr;
      bit                          is_status;
      bit                          timed_out;
      bit                          abort;
      wb_rsp_t                     got;
      wb_rsp_t                     exp_rsp;

      wb_req       = '0;
      rst_n        = 1'b0;
      seed         = 54827;
      line_no      = 0;
      mismatch_cnt = 0;
      timeout_cnt  = 0;
      other_cnt    = 0;
      transfer_cnt = 0;
      abort        = 1'b0;

      repeat (RESET_CYCLES) @(posedge clk);
      #(DRIVE_DLY);
      rst_n = 1'b1;
      @(posedge clk);
      #(DRIVE_DLY);

      fd = $fopen("tests/fifo_input.txt", "r");
      if (fd == 0) begin
         $display("ERROR: cannot open the command file tests/fifo_input.txt");
         other_cnt++;
      end else begin
         while (!abort && $fgets(line_buf, fd) != 0) begin
            line_no++;
            nf = $sscanf(line_buf, "%s %d %h %d %h", op, count, data, err_flag, exp_word);
            // comment and blank lines fall through here
            if (nf == 5) begin
               if (!decode_op(op, we, adr)) begin
                  $display("ERROR: line %0d holds an unknown operation", line_no);
                  other_cnt++;
               end else begin
                  is_status = (op == "status");
                  for (i = 0; i < count && !abort; i++) begin
                     gap = $unsigned($random(seed)) % 4;
                     repeat (gap) begin
                        @(posedge clk);
                        #(DRIVE_DLY);
                     end
                     // repeated pushes count the byte up from the given value
                     run_transfer(we, adr, data + i, got, timed_out);
                     if (timed_out) begin
                        timeout_cnt++;
                        abort = 1'b1;
                     end else begin
                        exp_rsp.ack = (err_flag == 0);
                        exp_rsp.err = (err_flag != 0);
                        exp_rsp.dat = (err_flag != 0) ? '0 : exp_word;
                        // only the unused bits of a status word are compared here
                        mask = (is_status && err_flag == 0) ? 32'hffff_fc80 : '1;
                        check_rsp(exp_rsp, got, mask);
                        if (is_status && err_flag == 0) begin
                           check_status(word_to_status(exp_word), word_to_status(got.dat));
                        end
                     end
                  end
               end
            end
         end
         $fclose(fd);
      end

      if (transfer_cnt == 0) begin
         $display("ERROR: no bus transfer was run");
         other_cnt++;
      end

      $display("transfers %0d, mismatches %0d, timeouts %0d, other errors %0d",
               transfer_cnt, mismatch_cnt, timeout_cnt, other_cnt);
      if (mismatch_cnt == 0 && timeout_cnt == 0 && other_cnt == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

// File: tests/fifo_input.txt
# columns: op count data(hex) err expected(hex)
# status word holds level in 6:0, words_empty in 8, full in 9
status    1  00 0 100
pop       1  00 1 0
push      1  11 0 0
push      1  22 0 0
push      1  33 0 0
status    1  00 0 103
pop       1  00 1 0
status    1  00 0 103
push      1  44 0 0
status    1  00 0 004
pop       1  00 0 44332211
status    1  00 0 100
rd_push   1  00 1 0
wr_pop    1  5a 1 0
wr_status 1  5a 1 0
rd_adr3   1  00 1 0
wr_adr3   1  5a 1 0
status    1  00 0 100
push      60 80 0 0
status    1  00 0 03c
push      4  bc 0 0
status    1  00 0 240
push      1  ee 1 0
status    1  00 0 240
pop       1  00 0 83828180
status    1  00 0 03c
push      4  c0 0 0
status    1  00 0 240
pop       1  00 0 87868584
pop       1  00 0 8b8a8988
push      2  c4 0 0
status    1  00 0 03a
pop       1  00 0 8f8e8d8c
pop       1  00 0 93929190
pop       1  00 0 97969594
pop       1  00 0 9b9a9998
pop       1  00 0 9f9e9d9c
pop       1  00 0 a3a2a1a0
pop       1  00 0 a7a6a5a4
pop       1  00 0 abaaa9a8
pop       1  00 0 afaeadac
pop       1  00 0 b3b2b1b0
pop       1  00 0 b7b6b5b4
pop       1  00 0 bbbab9b8
pop       1  00 0 bfbebdbc
pop       1  00 0 c3c2c1c0
status    1  00 0 102
pop       1  00 1 0
status    1  00 0 102
push      2  c6 0 0
status    1  00 0 004
pop       1  00 0 c7c6c5c4
status    1  00 0 100

// File: src.f
+incdir+include
logic/asym_fifo_pkg.sv
logic/ram_2p_bank.sv
logic/ram_2p_asym_wler.sv
logic/asym_fifo_ctrl.sv
logic/asym_fifo_wb.sv
logic/asym_fifo_top.sv
tests/asym_fifo_tb.sv

// File: Bender.yml
package:
  name: asym_fifo

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/asym_fifo_pkg.sv
      - logic/ram_2p_bank.sv
      - logic/ram_2p_asym_wler.sv
      - logic/asym_fifo_ctrl.sv
      - logic/asym_fifo_wb.sv
      - logic/asym_fifo_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/asym_fifo_tb.sv
